//--- run_sim.sh
#!/bin/sh
# Build and run the SD card model testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_sd_card_vip -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1

//--- sim/tb_sd_card_vip.sv
////////////////////
// Testbench for the SD card model that sends a table of command frames
// and checks each serial response
////////////////////

`include "sd_vip_defines.svh"

module tb_sd_card_vip
    import sd_vip_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS     = 19;
    localparam int RESP_TIMEOUT = 200;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        int          idle;
        bit          has_resp;
        logic [31:0] expected;
        bit          bad_crc;
    } row_t;

    logic       i_clk;
    logic       i_nrst;
    logic       i_cmd;
    logic       o_cmd;
    logic       o_cmd_oe;
    row_t       rows [NUM_ROWS];
    int         error_count;
    int         rows_failed;
    logic [7:0] pat_a;
    logic [7:0] pat_b;

    sd_card_vip UUT (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_cmd    (i_cmd),
        .o_cmd    (o_cmd),
        .o_cmd_oe (o_cmd_oe)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Host side CRC7 with x^7 + x^3 + 1 over the first 40 frame bits
    function automatic logic [6:0] host_crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) crc = crc ^ 7'h09;
        end
        return crc;
    endfunction

    function automatic logic [47:0] build_frame(input logic [5:0] index,
                                                input logic [31:0] arg, input bit bad_crc);
        logic [39:0] head;
        logic [6:0]  crc;
        head = {1'b0, 1'b1, index, arg};
        crc  = host_crc7(head);
        if (bad_crc) crc[0] = ~crc[0];
        return {head, crc, 1'b1};
    endfunction

    // CMD8 answer when argument bits 13..8 are all set
    function automatic logic [31:0] if_cond_word(input logic [7:0] pat);
        return {18'h0, `SD_PCIE_1V2, `SD_PCIE_AVAIL, `SD_VHS, pat};
    endfunction

    task automatic set_row(input int n, input logic [5:0] index, input logic [31:0] arg,
                           input int idle, input bit has_resp, input logic [31:0] expected,
                           input bit bad_crc);
        rows[n] = '{index, arg, idle, has_resp, expected, bad_crc};
    endtask

    task automatic fill_table();
        set_row(0,  CMD_GO_IDLE, 32'h0, 5, 1, 32'h0, 0);
        set_row(1,  CMD_APP_CMD, 32'h0, 3, 1, 32'h0, 0);
        // Still powering up so the busy bit is low and the card stays idle
        set_row(2,  CMD_SD_SEND_OP_COND, 32'h00ff_8000, 3, 1, 32'h00ff_8000, 0);
        set_row(3,  CMD_SEND_IF_COND, {18'h0, 6'h3f, pat_a}, 3, 1, if_cond_word(pat_a), 0);
        set_row(4,  CMD_APP_CMD, 32'h0, 800, 1, 32'h0, 0);
        set_row(5,  CMD_SD_SEND_OP_COND, 32'h4030_0000, 3, 1, 32'h8030_0000, 0);
        set_row(6,  CMD_SEND_IF_COND, {18'h0, 6'h3f, pat_b}, 3, 1, 32'hffff_ffff, 0);
        set_row(7,  CMD_VOLTAGE_SWITCH, 32'h0, 3, 1, 32'h0, 0);
        set_row(8,  CMD_ALL_SEND_CID, 32'h0, 3, 1, `SD_CARD_CID, 0);
        set_row(9,  CMD_SEND_RCA, 32'h0, 3, 1, {`SD_CARD_RCA, 16'h0}, 0);
        set_row(10, CMD_ALL_SEND_CID, 32'h0, 3, 1, 32'hffff_ffff, 0);
        set_row(11, CMD_GO_IDLE, 32'h0, 3, 1, 32'h0, 0);
        set_row(12, CMD_SEND_RCA, 32'h0, 3, 1, 32'hffff_ffff, 0);
        set_row(13, CMD_SEND_IF_COND, {18'h0, 6'h3f, pat_b}, 3, 1, if_cond_word(pat_b), 0);
        set_row(14, CMD_APP_CMD, 32'h0, 3, 0, 32'h0, 1);
        set_row(15, CMD_SEND_IF_COND, {18'h0, 6'h3f, pat_a}, 3, 1, if_cond_word(pat_a), 0);
        set_row(16, CMD_APP_CMD, 32'h0, 3, 1, 32'h0, 0);
        // Empty window puts the card in the inactive state
        set_row(17, CMD_SD_SEND_OP_COND, 32'h4000_0000, 3, 1, 32'h8000_0000, 0);
        set_row(18, CMD_GO_IDLE, 32'h0, 3, 0, 32'h0, 0);
    endtask

    task automatic send_frame(input logic [47:0] frame);
        int i;
        for (i = 47; i >= 0; i--) begin
            @(posedge i_clk);
            i_cmd <= frame[i];
        end
        @(posedge i_clk);
        i_cmd <= 1'b1;
    endtask

    task automatic report_error(input int n, input string msg);
        $display("error at %0t: row %0d, %s", $time, n, msg);
        error_count++;
    endtask

    // Outputs change after the rising edge and are sampled on the falling edge
    task automatic check_response(input int n);
        logic [47:0] frame;
        int          waited;
        int          i;
        bit          seen;
        bit          oe_drop;
        seen    = 0;
        waited  = 0;
        oe_drop = 0;
        while (!seen && waited < RESP_TIMEOUT) begin
            @(negedge i_clk);
            if (o_cmd_oe) seen = 1;
            else waited++;
        end
        if (!seen) begin
            $display("row %0d: card gave no response within %0d cycles", n, RESP_TIMEOUT);
            error_count++;
        end else begin
            frame[47] = o_cmd;
            for (i = 46; i >= 0; i--) begin
                @(negedge i_clk);
                if (!o_cmd_oe) oe_drop = 1;
                frame[i] = o_cmd;
            end
            @(negedge i_clk);
            if (oe_drop) report_error(n, "output enable dropped inside the frame");
            if (o_cmd_oe) report_error(n, "output enable held past 48 bits");
            if (frame[47] !== 1'b0) report_error(n, "start bit not 0");
            if (frame[46] !== 1'b0) report_error(n, "direction bit not 0");
            if (frame[45:40] !== rows[n].index)
                report_error(n, $sformatf("index %0d, expected %0d", frame[45:40], rows[n].index));
            if (frame[39:8] !== rows[n].expected)
                report_error(n, $sformatf("data %h, expected %h", frame[39:8], rows[n].expected));
            if (frame[7:1] !== host_crc7(frame[47:8]))
                report_error(n, $sformatf("crc %h, expected %h", frame[7:1],
                                          host_crc7(frame[47:8])));
            if (frame[0] !== 1'b1) report_error(n, "end bit not 1");
        end
    endtask

    task automatic check_silence(input int n);
        int i;
        bit seen;
        seen = 0;
        for (i = 0; i < RESP_TIMEOUT; i++) begin
            @(negedge i_clk);
            if (o_cmd_oe) seen = 1;
        end
        if (seen) begin
            $display("row %0d: card answered a command that should get no response", n);
            error_count++;
        end
    endtask

    initial begin
        int n;
        int errs_before;
        i_nrst      = 1'b0;
        i_cmd       = 1'b1;
        error_count = 0;
        rows_failed = 0;
        pat_a       = 8'($urandom(32'h7b2f));
        pat_b       = 8'($urandom);
        fill_table();
        repeat (10) @(posedge i_clk);
        i_nrst <= 1'b1;
        for (n = 0; n < NUM_ROWS; n++) begin
            errs_before = error_count;
            repeat (rows[n].idle) @(posedge i_clk);
            send_frame(build_frame(rows[n].index, rows[n].arg, rows[n].bad_crc));
            if (rows[n].has_resp) check_response(n);
            else check_silence(n);
            if (error_count == errs_before) begin
                $display("row %0d cmd %0d: ok", n, rows[n].index);
            end else begin
                $display("row %0d cmd %0d: failed", n, rows[n].index);
                rows_failed++;
            end
        end
        $display("rows run %0d, rows failed %0d, errors %0d", NUM_ROWS, rows_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- source/sd_card_ctrl.sv
////////////////////
// Card state machine, decodes commands and releases delayed responses
////////////////////

`include "sd_vip_defines.svh"

module sd_card_ctrl
    import sd_vip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_cmd_valid,
    input  logic [5:0]  i_cmd_index,
    input  logic [31:0] i_cmd_arg,
    input  logic        i_tx_busy,
    output logic        o_resp_valid,
    output logic [5:0]  o_resp_index,
    output logic [31:0] o_resp_data
);

    localparam int PWR_W = $clog2(`SD_POWERUP_DELAY + 1);
    localparam int DLY_W = $clog2(`SD_DELAY_LONG + 1);

    sd_state_e        state;
    sd_state_e        state_nxt;
    sd_cmd_e          cmd;
    logic [PWR_W-1:0] powerup_cnt;
    logic             powerup_done;
    logic [DLY_W-1:0] delay_cnt;
    logic [DLY_W-1:0] delay_nxt;
    logic             pending;
    logic             has_resp;
    logic [31:0]      resp_word;
    logic [23:0]      ocr_window;

    assign cmd        = sd_cmd_e'(i_cmd_index);
    assign ocr_window = i_cmd_arg[23:0] & `SD_VDD_WINDOW;

    // Response word, delay and next state for the incoming command
    always_comb begin
        state_nxt = state;
        has_resp  = 1'b1;
        resp_word = '1;
        delay_nxt = DLY_W'(`SD_DELAY_SHORT);
        case (state)
            STATE_IDLE: begin
                case (cmd)
                    CMD_GO_IDLE: begin
                        resp_word = '0;
                        delay_nxt = DLY_W'(`SD_DELAY_LONG);
                    end
                    CMD_SEND_IF_COND: begin
                        resp_word        = '0;
                        resp_word[13]    = i_cmd_arg[13] & `SD_PCIE_1V2;
                        resp_word[12]    = i_cmd_arg[12] & `SD_PCIE_AVAIL;
                        resp_word[11:8]  = i_cmd_arg[11:8] & `SD_VHS;
                        resp_word[7:0]   = i_cmd_arg[7:0];
                        delay_nxt        = DLY_W'(`SD_DELAY_LONG);
                    end
                    CMD_APP_CMD: begin
                        resp_word = '0;
                    end
                    CMD_SD_SEND_OP_COND: begin
                        // Bit 31 reads 1 once the card has finished powering up
                        resp_word        = '0;
                        resp_word[31]    = powerup_done;
                        resp_word[23:0]  = ocr_window;
                        delay_nxt        = DLY_W'(`SD_DELAY_LONG);
                        if (ocr_window == 24'h0) begin
                            state_nxt = STATE_INA;
                        end else if (powerup_done) begin
                            state_nxt = STATE_READY;
                        end
                    end
                    default: ;
                endcase
            end
            STATE_READY: begin
                case (cmd)
                    CMD_GO_IDLE: begin
                        resp_word = '0;
                        state_nxt = STATE_IDLE;
                    end
                    CMD_ALL_SEND_CID: begin
                        resp_word = `SD_CARD_CID;
                        state_nxt = STATE_IDENT;
                    end
                    CMD_VOLTAGE_SWITCH: begin
                        resp_word = '0;
                    end
                    default: ;
                endcase
            end
            STATE_IDENT: begin
                case (cmd)
                    CMD_GO_IDLE: begin
                        resp_word = '0;
                        state_nxt = STATE_IDLE;
                    end
                    CMD_SEND_RCA: begin
                        resp_word = {`SD_CARD_RCA, 16'h0000};
                        state_nxt = STATE_STBY;
                    end
                    default: ;
                endcase
            end
            STATE_STBY: begin
                if (cmd == CMD_GO_IDLE) begin
                    resp_word = '0;
                    state_nxt = STATE_IDLE;
                end
            end
            // Inactive card never answers
            default: has_resp = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= STATE_IDLE;
            powerup_cnt  <= '0;
            powerup_done <= 1'b0;
            delay_cnt    <= '0;
            pending      <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= 1'b0;
            if (!powerup_done) begin
                if (powerup_cnt == PWR_W'(`SD_POWERUP_DELAY)) begin
                    powerup_done <= 1'b1;
                end else begin
                    powerup_cnt <= powerup_cnt + 1'b1;
                end
            end
            if (pending) begin
                if (delay_cnt == '0) begin
                    pending      <= 1'b0;
                    o_resp_valid <= 1'b1;
                end else begin
                    delay_cnt <= delay_cnt - 1'b1;
                end
            end else if (i_cmd_valid) begin
                state <= state_nxt;
                if (has_resp) begin
                    pending   <= 1'b1;
                    delay_cnt <= delay_nxt;
                end
            end
        end
    end

    // Stored response, held until the transmitter takes it
    always_ff @(posedge i_clk) begin
        if (i_cmd_valid && !pending && has_resp) begin
            o_resp_index <= i_cmd_index;
            o_resp_data  <= resp_word;
        end
    end

    a_no_cmd_when_pending: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_cmd_valid |-> !pending
    ) else $error("Command dropped, previous response still pending");

    a_tx_free_on_resp: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |-> !i_tx_busy
    ) else $error("Response issued while transmitter busy");

endmodule

//--- source/sd_card_vip.sv
////////////////////
// SD card command-path model, receiver to controller to transmitter
////////////////////

module sd_card_vip (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_cmd,
    output logic o_cmd,
    output logic o_cmd_oe
);

    logic        cmd_valid;
    logic [5:0]  cmd_index;
    logic [31:0] cmd_arg;
    logic        resp_valid;
    logic [5:0]  resp_index;
    logic [31:0] resp_data;
    logic        tx_busy;

    sd_cmd_rx u_cmd_rx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cmd       (i_cmd),
        .o_cmd_valid (cmd_valid),
        .o_cmd_index (cmd_index),
        .o_cmd_arg   (cmd_arg)
    );

    sd_card_ctrl u_card_ctrl (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_cmd_valid  (cmd_valid),
        .i_cmd_index  (cmd_index),
        .i_cmd_arg    (cmd_arg),
        .i_tx_busy    (tx_busy),
        .o_resp_valid (resp_valid),
        .o_resp_index (resp_index),
        .o_resp_data  (resp_data)
    );

    // Busy feeds back to the controller for its overlap check
    sd_resp_tx u_resp_tx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_resp_valid (resp_valid),
        .i_resp_index (resp_index),
        .i_resp_data  (resp_data),
        .o_busy       (tx_busy),
        .o_cmd        (o_cmd),
        .o_cmd_oe     (o_cmd_oe)
    );

endmodule

//--- source/sd_cmd_rx.sv
////////////////////
// CMD line receiver, turns host frames into index/argument strobes
////////////////////

`include "sd_vip_defines.svh"

module sd_cmd_rx
    import sd_vip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_cmd,
    output logic        o_cmd_valid,
    output logic [5:0]  o_cmd_index,
    output logic [31:0] o_cmd_arg
);

    localparam int CNT_W     = $clog2(`SD_FRAME_BITS);
    localparam int CRC_BITS  = `SD_FRAME_BITS - 8;
    localparam int LAST_BIT  = `SD_FRAME_BITS - 1;

    logic                      busy;
    logic [CNT_W-1:0]          bit_cnt;
    logic [6:0]                crc;
    logic [`SD_FRAME_BITS-2:0] shreg;
    logic                      frame_ok;
    logic                      last_bit;

    assign last_bit = busy && (bit_cnt == CNT_W'(LAST_BIT));

    // At the end bit, shreg holds start..CRC with the start bit at the top
    assign frame_ok = shreg[`SD_FRAME_BITS-3] && (crc == shreg[6:0]) && i_cmd;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy        <= 1'b0;
            bit_cnt     <= '0;
            crc         <= '0;
            o_cmd_valid <= 1'b0;
        end else begin
            o_cmd_valid <= 1'b0;
            if (!busy) begin
                // Line idles high, a low bit opens a frame
                if (!i_cmd) begin
                    busy    <= 1'b1;
                    bit_cnt <= CNT_W'(1);
                    crc     <= sd_crc7_step(7'h00, i_cmd);
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < CNT_W'(CRC_BITS)) begin
                    crc <= sd_crc7_step(crc, i_cmd);
                end
                if (last_bit) begin
                    busy        <= 1'b0;
                    o_cmd_valid <= frame_ok;
                end
            end
        end
    end

    // Shift history and decoded fields
    always_ff @(posedge i_clk) begin
        shreg <= {shreg[`SD_FRAME_BITS-3:0], i_cmd};
        if (last_bit) begin
            o_cmd_index <= shreg[44:39];
            o_cmd_arg   <= shreg[38:7];
        end
    end

    a_single_strobe: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_cmd_valid |=> !o_cmd_valid
    ) else $error("o_cmd_valid held for more than one cycle");

endmodule

//--- source/sd_resp_tx.sv
////////////////////
// Response serializer, drives CMD with CRC7 and output enable
////////////////////

`include "sd_vip_defines.svh"

module sd_resp_tx
    import sd_vip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_resp_valid,
    input  logic [5:0]  i_resp_index,
    input  logic [31:0] i_resp_data,
    output logic        o_busy,
    output logic        o_cmd,
    output logic        o_cmd_oe
);

    localparam int CNT_W     = $clog2(`SD_FRAME_BITS);
    localparam int CRC_START = `SD_FRAME_BITS - 8;
    localparam int LAST_BIT  = `SD_FRAME_BITS - 1;

    logic [`SD_FRAME_BITS-1:0] shreg;
    logic [CNT_W-1:0]          bit_cnt;
    logic [6:0]                crc;
    logic                      in_crc;
    logic                      load;

    assign load   = i_resp_valid && !o_cmd_oe;
    assign in_crc = (bit_cnt >= CNT_W'(CRC_START)) && (bit_cnt < CNT_W'(LAST_BIT));
    // CRC bits replace the zero placeholders in the shift register
    assign o_cmd  = !o_cmd_oe ? 1'b1 : (in_crc ? crc[6] : shreg[`SD_FRAME_BITS-1]);
    assign o_busy = o_cmd_oe;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_cmd_oe <= 1'b0;
            bit_cnt  <= '0;
            crc      <= '0;
        end else if (!o_cmd_oe) begin
            if (i_resp_valid) begin
                o_cmd_oe <= 1'b1;
                bit_cnt  <= '0;
                crc      <= '0;
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt < CNT_W'(CRC_START)) begin
                crc <= sd_crc7_step(crc, shreg[`SD_FRAME_BITS-1]);
            end else begin
                crc <= {crc[5:0], 1'b0};
            end
            if (bit_cnt == CNT_W'(LAST_BIT)) begin
                o_cmd_oe <= 1'b0;
            end
        end
    end

    // Start 0, direction 0 (card to host), index, data, CRC slot, end 1
    always_ff @(posedge i_clk) begin
        if (load) begin
            shreg <= {1'b0, 1'b0, i_resp_index, i_resp_data, 7'h00, 1'b1};
        end else if (o_cmd_oe) begin
            shreg <= {shreg[`SD_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

//--- source/sd_vip_defines.svh
////////////////////
// Constants for the SD card command-path model
// Include wherever frame sizes, delays or card identity are needed
////////////////////

`ifndef SD_VIP_DEFINES_SVH
`define SD_VIP_DEFINES_SVH

// Command and response frame length in bits
`define SD_FRAME_BITS       48

// Power-up busy time seen by ACMD41, in clock cycles
`define SD_POWERUP_DELAY    700

// Response delays, in clock cycles
`define SD_DELAY_LONG       20
`define SD_DELAY_SHORT      2

// Card capabilities reported by CMD8 and ACMD41
`define SD_VHS              4'h1
`define SD_PCIE_1V2         1'b0
`define SD_PCIE_AVAIL       1'b0
`define SD_VDD_WINDOW       24'hff8000

// Card identity
`define SD_CARD_RCA         16'h1234
`define SD_CARD_CID         32'h5344_4331

`endif

//--- source/sd_vip_pkg.sv
////////////////////
// Types and the CRC7 step shared by the SD card model stages
////////////////////

package sd_vip_pkg;

    // Identification-mode card states
    typedef enum logic [2:0] {
        STATE_IDLE,
        STATE_READY,
        STATE_IDENT,
        STATE_STBY,
        STATE_INA
    } sd_state_e;

    // Command indices understood by the card
    typedef enum logic [5:0] {
        CMD_GO_IDLE         = 6'd0,
        CMD_ALL_SEND_CID    = 6'd2,
        CMD_SEND_RCA        = 6'd3,
        CMD_SEND_IF_COND    = 6'd8,
        CMD_VOLTAGE_SWITCH  = 6'd11,
        CMD_SD_SEND_OP_COND = 6'd41,
        CMD_APP_CMD         = 6'd55
    } sd_cmd_e;

    // One serial step of CRC7, polynomial x^7 + x^3 + 1
    function automatic logic [6:0] sd_crc7_step(
        input logic [6:0] crc,
        input logic       din
    );
        logic fb;
        fb = din ^ crc[6];
        // Feedback lands on taps 3 and 0
        sd_crc7_step = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    endfunction

endpackage

//--- tb.f
+incdir+source
source/sd_vip_pkg.sv
source/sd_cmd_rx.sv
source/sd_card_ctrl.sv
source/sd_resp_tx.sv
source/sd_card_vip.sv
sim/tb_sd_card_vip.sv
